//--- source/dcache_pkg.sv
package dcache_pkg;

  // Cache geometry
  localparam int LINES          = 16;
  localparam int WORDS_PER_LINE = 4;
  localparam int IDX_BITS       = 4;
  localparam int OFS_BITS       = 2;
  // Byte offset inside a word takes the last 2 bits
  localparam int TAG_BITS       = 32 - IDX_BITS - OFS_BITS - 2;

  typedef logic [31:0]                  addr_t;
  typedef logic [31:0]                  word_t;
  // Word 0 sits in the low bits
  typedef logic [WORDS_PER_LINE*32-1:0] line_t;
  typedef logic [IDX_BITS-1:0]          index_t;
  typedef logic [TAG_BITS-1:0]          tag_t;
  typedef logic [3:0]                   byte_sel_t;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    WRITEBACK,
    REFILL,
    FLUSH_CHECK,
    FLUSH_WB,
    FLUSH_NEXT,
    DONE
  } dcache_state_e;

  // Store buffer to cache
  typedef struct packed {
    logic      req;
    logic      w_en;
    addr_t     addr;
    word_t     w_data;
    byte_sel_t sel_byte;
  } stb2dcache_t;

  // Cache to store buffer
  typedef struct packed {
    logic  ack;
    word_t r_data;
  } dcache2stb_t;

  // Data memory returns one full line per ack
  typedef struct packed {
    logic  ack;
    line_t r_data;
  } mem2dcache_t;

  // Cache to data memory with a line aligned addr
  typedef struct packed {
    logic  req;
    logic  w_en;
    addr_t addr;
    line_t w_data;
  } dcache2mem_t;

endpackage

//--- source/dcache_controller.sv
module dcache_controller (
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic                      dmem_sel_i,
  input  logic                      flush_i,
  input  logic                      kill_i,
  input  logic                      stb_req_i,
  input  logic                      stb_wr_i,
  input  logic                      hit_i,
  input  logic                      victim_dirty_i,
  input  logic                      mem_ack_i,
  input  logic                      last_i,
  output dcache_pkg::dcache_state_e state_o,
  output logic                      stb_ack_o,
  output logic                      mem_req_o,
  output logic                      mem_wr_o,
  output logic                      mem_kill_o,
  output logic                      array_wr_o,
  output logic                      line_wr_o,
  output logic                      line_clean_o,
  output logic                      wb_sel_flush_o,
  output logic                      cnt_clear_o,
  output logic                      cnt_step_o,
  output logic                      flush_done_o
);

  dcache_pkg::dcache_state_e state_q, state_d;

  logic mem_hold_q;
  logic stb_ack_q;
  logic mem_kill_q;
  logic flush_done_q;
  logic mem_state;
  logic mem_done;
  logic kill_now;

  assign mem_state = (state_q == dcache_pkg::WRITEBACK) || (state_q == dcache_pkg::REFILL) ||
                     (state_q == dcache_pkg::FLUSH_WB);

  // Request drops for one cycle after every ack
  assign mem_req_o = mem_state && !mem_hold_q;
  assign mem_wr_o  = (state_q == dcache_pkg::WRITEBACK) || (state_q == dcache_pkg::FLUSH_WB);
  assign mem_done  = mem_req_o && mem_ack_i;

  // Kill is honoured only while a lookup miss is being served
  assign kill_now = kill_i &&
                    ((state_q == dcache_pkg::WRITEBACK) || (state_q == dcache_pkg::REFILL));

  assign array_wr_o     = (state_q == dcache_pkg::LOOKUP) && hit_i && stb_wr_i;
  assign line_wr_o      = (state_q == dcache_pkg::REFILL) && mem_done && !kill_i;
  assign line_clean_o   = mem_done && (((state_q == dcache_pkg::WRITEBACK) && !kill_i) ||
                                       (state_q == dcache_pkg::FLUSH_WB));
  assign wb_sel_flush_o = (state_q == dcache_pkg::FLUSH_CHECK) ||
                          (state_q == dcache_pkg::FLUSH_WB) ||
                          (state_q == dcache_pkg::FLUSH_NEXT);
  assign cnt_clear_o    = (state_q == dcache_pkg::IDLE) && flush_i;
  assign cnt_step_o     = (state_q == dcache_pkg::FLUSH_NEXT);

  assign state_o      = state_q;
  assign stb_ack_o    = stb_ack_q;
  assign mem_kill_o   = mem_kill_q;
  assign flush_done_o = flush_done_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      dcache_pkg::IDLE: begin
        // Flush wins over a pending request; skip the cycle of our own ack
        if (flush_i) begin
          state_d = dcache_pkg::FLUSH_CHECK;
        end else if (dmem_sel_i && stb_req_i && !stb_ack_q) begin
          state_d = dcache_pkg::LOOKUP;
        end
      end
      dcache_pkg::LOOKUP: begin
        if (hit_i) begin
          state_d = dcache_pkg::IDLE;
        end else if (victim_dirty_i) begin
          state_d = dcache_pkg::WRITEBACK;
        end else begin
          state_d = dcache_pkg::REFILL;
        end
      end
      dcache_pkg::WRITEBACK: begin
        if (kill_i) begin
          state_d = dcache_pkg::IDLE;
        end else if (mem_done) begin
          state_d = dcache_pkg::REFILL;
        end
      end
      dcache_pkg::REFILL: begin
        if (kill_i) begin
          state_d = dcache_pkg::IDLE;
        end else if (mem_done) begin
          state_d = dcache_pkg::LOOKUP;
        end
      end
      dcache_pkg::FLUSH_CHECK: begin
        state_d = victim_dirty_i ? dcache_pkg::FLUSH_WB : dcache_pkg::FLUSH_NEXT;
      end
      dcache_pkg::FLUSH_WB: begin
        if (mem_done) begin
          state_d = dcache_pkg::FLUSH_NEXT;
        end
      end
      dcache_pkg::FLUSH_NEXT: begin
        state_d = last_i ? dcache_pkg::DONE : dcache_pkg::FLUSH_CHECK;
      end
      // Wait here until the flush request is withdrawn
      dcache_pkg::DONE: begin
        if (!flush_i) begin
          state_d = dcache_pkg::IDLE;
        end
      end
      default: state_d = dcache_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q      <= dcache_pkg::IDLE;
      mem_hold_q   <= 1'b0;
      stb_ack_q    <= 1'b0;
      mem_kill_q   <= 1'b0;
      flush_done_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      mem_hold_q   <= mem_done;
      stb_ack_q    <= (state_q == dcache_pkg::LOOKUP) && hit_i;
      mem_kill_q   <= kill_now;
      flush_done_q <= (state_q == dcache_pkg::FLUSH_NEXT) && last_i;
    end
  end

endmodule

//--- source/dcache_flush_counter.sv
module dcache_flush_counter (
  input  logic               clk,
  input  logic               rst_i,
  input  logic               clear_i,
  input  logic               step_i,
  output dcache_pkg::index_t index_o,
  output logic               last_o
);

  dcache_pkg::index_t index_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      index_q <= '0;
    end else if (clear_i) begin
      index_q <= '0;
    end else if (step_i) begin
      index_q <= index_q + 1'b1;
    end
  end

  assign index_o = index_q;

  // Final line of the walk
  assign last_o = (index_q == dcache_pkg::index_t'(dcache_pkg::LINES - 1));

endmodule

//--- source/dcache_datapath.sv
module dcache_datapath (
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  flush_i,
  input  logic                  array_wr_i,
  input  logic                  line_wr_i,
  input  logic                  line_clean_i,
  input  logic                  wb_sel_flush_i,
  input  dcache_pkg::index_t    flush_index_i,
  input  dcache_pkg::addr_t     stb_addr_i,
  input  dcache_pkg::word_t     stb_wdata_i,
  input  dcache_pkg::byte_sel_t sel_byte_i,
  input  dcache_pkg::line_t     mem_rdata_i,
  output logic                  hit_o,
  output logic                  victim_dirty_o,
  output dcache_pkg::word_t     stb_rdata_o,
  output dcache_pkg::addr_t     mem_addr_o,
  output dcache_pkg::line_t     mem_wdata_o
);

  logic [dcache_pkg::LINES-1:0] valid_q;
  logic [dcache_pkg::LINES-1:0] dirty_q;
  dcache_pkg::tag_t             tag_q  [dcache_pkg::LINES];
  dcache_pkg::line_t            data_q [dcache_pkg::LINES];

  logic [dcache_pkg::OFS_BITS-1:0] req_ofs;
  dcache_pkg::index_t              req_idx;
  dcache_pkg::tag_t                req_tag;
  dcache_pkg::index_t              victim_idx;

  // Address splits into tag, index, word offset and byte
  assign req_ofs = stb_addr_i[2 +: dcache_pkg::OFS_BITS];
  assign req_idx = stb_addr_i[2 + dcache_pkg::OFS_BITS +: dcache_pkg::IDX_BITS];
  assign req_tag = stb_addr_i[2 + dcache_pkg::OFS_BITS + dcache_pkg::IDX_BITS +:
                              dcache_pkg::TAG_BITS];

  assign victim_idx = wb_sel_flush_i ? flush_index_i : req_idx;

  assign hit_o          = valid_q[req_idx] && (tag_q[req_idx] == req_tag);
  assign victim_dirty_o = valid_q[victim_idx] && dirty_q[victim_idx];
  assign stb_rdata_o    = data_q[req_idx][req_ofs*32 +: 32];

  // A dirty victim is written back to its own address, otherwise the
  // request line is fetched
  always_comb begin
    if (victim_dirty_o) begin
      mem_addr_o = {tag_q[victim_idx], victim_idx, {(dcache_pkg::OFS_BITS + 2){1'b0}}};
    end else begin
      mem_addr_o = {req_tag, req_idx, {(dcache_pkg::OFS_BITS + 2){1'b0}}};
    end
  end

  assign mem_wdata_o = data_q[victim_idx];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      if (line_wr_i) begin
        valid_q[req_idx] <= 1'b1;
        dirty_q[req_idx] <= 1'b0;
      end
      if (array_wr_i) begin
        dirty_q[req_idx] <= 1'b1;
      end
      if (line_clean_i) begin
        dirty_q[victim_idx] <= 1'b0;
      end
      // Line passed by the flush walk
      if (flush_i) begin
        valid_q[flush_index_i] <= 1'b0;
        dirty_q[flush_index_i] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (line_wr_i) begin
      tag_q[req_idx]  <= req_tag;
      data_q[req_idx] <= mem_rdata_i;
    end else if (array_wr_i) begin
      for (int b = 0; b < 4; b++) begin
        if (sel_byte_i[b]) begin
          data_q[req_idx][req_ofs*32 + b*8 +: 8] <= stb_wdata_i[b*8 +: 8];
        end
      end
    end
  end

endmodule

//--- source/dcache_top.sv
module dcache_top (
  input  logic                    clk,
  input  logic                    rst_i,
  input  logic                    dmem_sel_i,
  input  logic                    dcache_flush_i,
  input  logic                    dcache_kill_i,
  input  logic                    stb_empty_i,
  input  dcache_pkg::stb2dcache_t stb2dcache_i,
  output dcache_pkg::dcache2stb_t dcache2stb_o,
  input  dcache_pkg::mem2dcache_t mem2dcache_i,
  output dcache_pkg::dcache2mem_t dcache2mem_o,
  output logic                    dcache2mem_kill_o,
  output logic                    flush_done_o
);

  dcache_pkg::dcache_state_e ctrl_state;
  dcache_pkg::index_t        flush_index;
  dcache_pkg::word_t         stb_rdata;
  dcache_pkg::addr_t         mem_addr;
  dcache_pkg::line_t         mem_wdata;

  logic flush_req;
  logic hit;
  logic victim_dirty;
  logic stb_ack;
  logic mem_req;
  logic mem_wr;
  logic array_wr;
  logic line_wr;
  logic line_clean;
  logic wb_sel_flush;
  logic cnt_clear;
  logic cnt_step;
  logic last;

  // Pending stores must drain before lines are written back
  assign flush_req = dcache_flush_i && stb_empty_i;

  dcache_controller u_controller (
    .clk            (clk),
    .rst_i          (rst_i),
    .dmem_sel_i     (dmem_sel_i),
    .flush_i        (flush_req),
    .kill_i         (dcache_kill_i),
    .stb_req_i      (stb2dcache_i.req),
    .stb_wr_i       (stb2dcache_i.w_en),
    .hit_i          (hit),
    .victim_dirty_i (victim_dirty),
    .mem_ack_i      (mem2dcache_i.ack),
    .last_i         (last),
    .state_o        (ctrl_state),
    .stb_ack_o      (stb_ack),
    .mem_req_o      (mem_req),
    .mem_wr_o       (mem_wr),
    .mem_kill_o     (dcache2mem_kill_o),
    .array_wr_o     (array_wr),
    .line_wr_o      (line_wr),
    .line_clean_o   (line_clean),
    .wb_sel_flush_o (wb_sel_flush),
    .cnt_clear_o    (cnt_clear),
    .cnt_step_o     (cnt_step),
    .flush_done_o   (flush_done_o)
  );

  dcache_flush_counter u_flush_counter (
    .clk     (clk),
    .rst_i   (rst_i),
    .clear_i (cnt_clear),
    .step_i  (cnt_step),
    .index_o (flush_index),
    .last_o  (last)
  );

  // The counter step also retires the line just examined
  dcache_datapath u_datapath (
    .clk            (clk),
    .rst_i          (rst_i),
    .flush_i        (cnt_step),
    .array_wr_i     (array_wr),
    .line_wr_i      (line_wr),
    .line_clean_i   (line_clean),
    .wb_sel_flush_i (wb_sel_flush),
    .flush_index_i  (flush_index),
    .stb_addr_i     (stb2dcache_i.addr),
    .stb_wdata_i    (stb2dcache_i.w_data),
    .sel_byte_i     (stb2dcache_i.sel_byte),
    .mem_rdata_i    (mem2dcache_i.r_data),
    .hit_o          (hit),
    .victim_dirty_o (victim_dirty),
    .stb_rdata_o    (stb_rdata),
    .mem_addr_o     (mem_addr),
    .mem_wdata_o    (mem_wdata)
  );

  assign dcache2stb_o = '{ack: stb_ack, r_data: stb_rdata};
  assign dcache2mem_o = '{req: mem_req, w_en: mem_wr, addr: mem_addr, w_data: mem_wdata};

endmodule

//--- tb/dcache_checker.sv
module dcache_checker (
  input logic                      clk,
  input logic                      rst_i,
  input logic                      kill_i,
  input dcache_pkg::dcache_state_e state_i,
  input dcache_pkg::dcache2stb_t   stb_rsp_i,
  input dcache_pkg::dcache2mem_t   mem_req_i,
  input dcache_pkg::mem2dcache_t   mem_rsp_i,
  input logic                      mem_kill_i,
  input logic                      flush_done_i
);

  // Number of failed assertions
  int fail_cnt = 0;

  // Hit ack is a single-cycle pulse
  ack_pulse: assert property (@(posedge clk) disable iff (rst_i)
    stb_rsp_i.ack |=> !stb_rsp_i.ack)
    else begin
      $error("store buffer ack high for two cycles");
      fail_cnt++;
    end

  // A refilled line hits on the lookup that follows
  refill_hit: assert property (@(posedge clk) disable iff (rst_i)
    state_i == dcache_pkg::LOOKUP && $past(state_i) == dcache_pkg::REFILL |=>
      stb_rsp_i.ack)
    else begin
      $error("lookup after a refill did not hit");
      fail_cnt++;
    end

  // Memory request held with stable fields until acked or killed
  mem_hold: assert property (@(posedge clk) disable iff (rst_i)
    mem_req_i.req && !mem_rsp_i.ack && !kill_i |=>
      mem_req_i.req && $stable(mem_req_i.addr) && $stable(mem_req_i.w_en) &&
      $stable(mem_req_i.w_data))
    else begin
      $error("memory request dropped or changed before its ack");
      fail_cnt++;
    end

  kill_pulse: assert property (@(posedge clk) disable iff (rst_i)
    mem_kill_i |=> !mem_kill_i)
    else begin
      $error("memory kill longer than one cycle");
      fail_cnt++;
    end

  // Quiet outputs right after any reset cycle
  reset_quiet: assert property (@(posedge clk)
    rst_i |=> !stb_rsp_i.ack && !mem_req_i.req && !mem_kill_i && !flush_done_i)
    else begin
      $error("output active after reset");
      fail_cnt++;
    end

endmodule

bind dcache_top dcache_checker u_checker (
  .clk          (clk),
  .rst_i        (rst_i),
  .kill_i       (dcache_kill_i),
  .state_i      (ctrl_state),
  .stb_rsp_i    (dcache2stb_o),
  .mem_req_i    (dcache2mem_o),
  .mem_rsp_i    (mem2dcache_i),
  .mem_kill_i   (dcache2mem_kill_o),
  .flush_done_i (flush_done_o)
);

//--- tb/dcache_tb.sv
module dcache_tb;

  localparam int MAX_RECS = 64;
  localparam int REC_LEN  = 6;
  // Each memory model word resets to its byte address XOR this key
  localparam logic [31:0] MEM_KEY = 32'h5A00_0000;

  logic clk = 1'b0;
  logic rst;
  logic dmem_sel;
  logic flush;
  logic kill;
  logic stb_empty;
  logic mem_kill;
  logic flush_done;

  dcache_pkg::stb2dcache_t stb_req;
  dcache_pkg::dcache2stb_t stb_rsp;
  dcache_pkg::mem2dcache_t mem_rsp = '0;
  dcache_pkg::dcache2mem_t mem_req;

  dcache_pkg::word_t mem_words [256];
  dcache_pkg::word_t golden    [256];
  logic [31:0]       pat       [MAX_RECS*REC_LEN];

  integer seed     = 31;
  int     wait_cnt = 0;
  logic   busy     = 1'b0;
  int     cycles   = 0;
  int     limit    = 0;
  int     n_rec    = 0;
  int     checks   = 0;
  int     errors   = 0;
  int     test_err = 0;
  int     cur_test = 0;

  always #2 clk = ~clk;

  dcache_top i_dut (
    .clk               (clk),
    .rst_i             (rst),
    .dmem_sel_i        (dmem_sel),
    .dcache_flush_i    (flush),
    .dcache_kill_i     (kill),
    .stb_empty_i       (stb_empty),
    .stb2dcache_i      (stb_req),
    .dcache2stb_o      (stb_rsp),
    .mem2dcache_i      (mem_rsp),
    .dcache2mem_o      (mem_req),
    .dcache2mem_kill_o (mem_kill),
    .flush_done_o      (flush_done)
  );

  // Line-wide memory model that acks 1 to 4 cycles after it sees a request
  always @(negedge clk) begin
    if (rst) begin
      for (int i = 0; i < 256; i++) begin
        mem_words[i] = (i * 4) ^ MEM_KEY;
      end
      mem_rsp.ack = 1'b0;
      busy        = 1'b0;
    end else if (mem_rsp.ack) begin
      mem_rsp.ack = 1'b0;
    end else if (!mem_req.req) begin
      // Killed request is abandoned
      busy = 1'b0;
    end else if (!busy) begin
      busy     = 1'b1;
      wait_cnt = 1 + {$random(seed)} % 4;
    end else begin
      wait_cnt = wait_cnt - 1;
      if (wait_cnt == 0) begin
        busy = 1'b0;
        for (int w = 0; w < 4; w++) begin
          if (mem_req.w_en) begin
            mem_words[{mem_req.addr[9:4], w[1:0]}] = mem_req.w_data[w*32 +: 32];
          end else begin
            mem_rsp.r_data[w*32 +: 32] = mem_words[{mem_req.addr[9:4], w[1:0]}];
          end
        end
        mem_rsp.ack = 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("Timeout: run still going after %0d cycles", cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  task automatic check_word(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAIL %0t: test %0d %s got %h expected %h", $time, cur_test, what, got, exp);
      errors++;
      test_err++;
    end
  endtask

  task automatic expect_true(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      $display("Test %0d: %s", cur_test, what);
      errors++;
      test_err++;
    end
  endtask

  task automatic report_test();
    $display("Test %0d finished with %0d errors", cur_test, test_err);
    test_err = 0;
  endtask

  // One store buffer access held until the ack and followed by a cycle with req low
  task automatic access(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                        input logic [3:0] sel, output logic [31:0] rdata);
    stb_req = '{req: 1'b1, w_en: wr, addr: addr, w_data: data, sel_byte: sel};
    do begin
      @(negedge clk);
    end while (!stb_rsp.ack);
    rdata       = stb_rsp.r_data;
    stb_req.req = 1'b0;
    @(negedge clk);
  endtask

  initial begin
    logic [31:0] op, addr, wdata, expv, rdata;
    logic [3:0]  sel;
    logic        saw_ack;
    logic        flush_early;
    rst       = 1'b1;
    dmem_sel  = 1'b1;
    flush     = 1'b0;
    kill      = 1'b0;
    stb_empty = 1'b0;
    stb_req   = '0;
    for (int i = 0; i < 256; i++) begin
      golden[i] = (i * 4) ^ MEM_KEY;
    end
    $readmemh("tb/dcache_patterns.hex", pat);
    while (n_rec < MAX_RECS && pat[n_rec*REC_LEN] !== 32'hF) begin
      n_rec++;
    end
    limit = 5 + n_rec * 40;
    repeat (5) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    for (int r = 0; r < n_rec; r++) begin
      op    = pat[r*REC_LEN];
      addr  = pat[r*REC_LEN+1];
      wdata = pat[r*REC_LEN+2];
      sel   = pat[r*REC_LEN+3][3:0];
      expv  = pat[r*REC_LEN+4];
      if (cur_test != 0 && pat[r*REC_LEN+5] != cur_test) begin
        report_test();
      end
      cur_test = pat[r*REC_LEN+5];
      case (op)
        0: begin
          access(1'b0, addr, wdata, sel, rdata);
          check_word($sformatf("read %h", addr), rdata, expv);
          check_word($sformatf("read %h vs stores", addr), rdata, golden[addr[9:2]]);
        end
        1: begin
          access(1'b1, addr, wdata, sel, rdata);
          for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
              golden[addr[9:2]][b*8 +: 8] = wdata[b*8 +: 8];
            end
          end
        end
        2: begin
          // Flush waits for the store buffer to report empty
          flush       = 1'b1;
          flush_early = 1'b0;
          repeat (4) begin
            @(negedge clk);
            flush_early |= mem_req.req || flush_done;
          end
          expect_true(!flush_early, "flush began before the store buffer reported empty");
          stb_empty = 1'b1;
          while (!flush_done) begin
            @(negedge clk);
          end
          flush     = 1'b0;
          stb_empty = 1'b0;
          @(negedge clk);
          for (int i = 0; i < 256; i++) begin
            check_word($sformatf("memory word %h", i * 4), mem_words[i], golden[i]);
          end
        end
        3: begin
          stb_req = '{req: 1'b1, w_en: 1'b0, addr: addr, w_data: '0, sel_byte: '0};
          while (!(mem_req.req && !mem_req.w_en)) begin
            @(negedge clk);
          end
          kill        = 1'b1;
          stb_req.req = 1'b0;
          @(negedge clk);
          kill = 1'b0;
          expect_true(mem_kill, "no memory kill pulse after a kill during refill");
          saw_ack = stb_rsp.ack;
          repeat (10) begin
            @(negedge clk);
            saw_ack |= stb_rsp.ack;
          end
          expect_true(!saw_ack, "killed request was acked");
        end
        4: begin
          check_word($sformatf("memory at %h", addr), mem_words[addr[9:2]], expv);
          for (int w = 0; w < 4; w++) begin
            check_word("memory line vs stores", mem_words[{addr[9:4], w[1:0]}],
                       golden[{addr[9:4], w[1:0]}]);
          end
        end
        5: begin
          dmem_sel = 1'b0;
          stb_req  = '{req: 1'b1, w_en: 1'b0, addr: addr, w_data: '0, sel_byte: '0};
          saw_ack  = 1'b0;
          repeat (10) begin
            @(negedge clk);
            saw_ack |= stb_rsp.ack;
          end
          expect_true(!saw_ack, "request acked while the data memory select was low");
          stb_req.req = 1'b0;
          dmem_sel    = 1'b1;
          @(negedge clk);
        end
        default: expect_true(1'b0, $sformatf("unknown opcode %h in pattern file", op));
      endcase
    end
    report_test();
    $display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
             i_dut.u_checker.fail_cnt);
    if (errors == 0 && i_dut.u_checker.fail_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- tb/dcache_patterns.hex
// op addr wdata sel expected test, one record per line
// op: 0 read, 1 write, 2 flush, 3 kill-read, 4 mem-check, 5 unselected read, f end
0 00000040 00000000 0 5A000040 01
0 00000044 00000000 0 5A000044 01
0 0000004C 00000000 0 5A00004C 01
1 00000044 11223344 3 00000000 02
1 00000044 AABBCCDD 8 00000000 02
0 00000044 00000000 0 AA003344 02
1 00000080 DEADBEEF F 00000000 02
0 00000080 00000000 0 DEADBEEF 02
0 00000084 00000000 0 5A000084 02
0 00000140 00000000 0 5A000140 03
4 00000044 00000000 0 AA003344 03
0 00000044 00000000 0 AA003344 03
1 000000C8 01020304 6 00000000 04
1 00000200 CAFEF00D F 00000000 04
2 00000000 00000000 0 00000000 04
4 000000C8 00000000 0 5A0203C8 04
4 00000200 00000000 0 CAFEF00D 04
0 00000080 00000000 0 DEADBEEF 04
3 00000300 00000000 0 00000000 05
0 00000300 00000000 0 5A000300 05
5 00000304 00000000 0 00000000 06
0 00000304 00000000 0 5A000304 06
F 00000000 00000000 0 00000000 00

//--- sources.f
source/dcache_pkg.sv
source/dcache_controller.sv
source/dcache_flush_counter.sv
source/dcache_datapath.sv
source/dcache_top.sv
tb/dcache_checker.sv
tb/dcache_tb.sv

//--- Makefile
TOP := dcache_tb

all: run

obj_dir/V$(TOP): sources.f $(wildcard source/*.sv tb/*.sv)
	verilator --binary --timing --assert -f sources.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
